// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := SpiFlashTb
FILELIST := SpiFlashTop.f

BUILD    := obj_dir
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== SpiFlashTop.f ====
src/SpiRegPkg.sv
src/SpiEnginePkg.sv
src/SpiWbSlave.sv
src/SpiCsr.sv
src/SpiSeq.sv
src/SpiShifter.sv
src/SpiFlashTop.sv
tb/SpiFlashTb_sva.sv
tb/SpiFlashTb.sv

// ==== src/SpiCsr.sv ====
/* Control and status registers of the SPI flash block
   Holds the transfer settings, the start and done flags and the received byte */
`timescale 1ns/1ps
`default_nettype none

module SpiCsr (
	input  wire logic                  iSCLK,
	input  wire logic                  iSRST,
	input  wire logic                  csrWe,
	input  wire logic                  csrRe,
	input  wire SpiRegPkg::csrOfsT     csrOfs,
	input  wire SpiRegPkg::csrDataT    csrWrData,
	input  wire logic                  seqBusy,
	input  wire logic                  seqDone,
	input  wire SpiEnginePkg::spiByteT seqRxByte,
	output SpiRegPkg::csrDataT         csrRdData,
	output logic                       startPulse,
	output SpiEnginePkg::spiByteT      txByte,
	output SpiEnginePkg::spiByteT      div,
	output SpiEnginePkg::spiByteT      csHold,
	output logic                       csCtrl
);

	import SpiRegPkg::*;
	import SpiEnginePkg::*;

	spiByteT rRxData;
	logic    rDone;
	logic    wrDiv;
	logic    wrCsHold;
	logic    wrTxData;
	logic    wrStart;
	logic    wrCsCtrl;
	logic    wrDone;

	//------------------------------
	// Write decode
	//------------------------------
	assign wrDiv    = csrWe & (csrOfs == cOfsDiv);
	assign wrCsHold = csrWe & (csrOfs == cOfsCsHold);
	assign wrTxData = csrWe & (csrOfs == cOfsTxData);
	assign wrStart  = csrWe & (csrOfs == cOfsStart);
	assign wrCsCtrl = csrWe & (csrOfs == cOfsCsCtrl);
	assign wrDone   = csrWe & (csrOfs == cOfsDone);

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			div        <= cDivReset;
			csHold     <= cCsHoldReset;
			csCtrl     <= 1'b1;	// Chip select idles high
			rDone      <= 1'b0;
			startPulse <= 1'b0;
		end
		else
		begin
			if (wrDiv)
				div <= csrWrData[7:0];
			if (wrCsHold)
				csHold <= csrWrData[7:0];
			if (wrCsCtrl)
				csCtrl <= csrWrData[0];
			// Completion wins over a clear in the same cycle
			if (seqDone)
				rDone <= 1'b1;
			else if (wrDone)
				rDone <= 1'b0;
			startPulse <= wrStart & csrWrData[0] & ~seqBusy;	// Dropped while busy
		end
	end

	always_ff @(posedge iSCLK)
	begin
		if (wrTxData)
			txByte <= csrWrData[7:0];
		if (seqDone)
			rRxData <= seqRxByte;
	end

	//------------------------------
	// Read mux
	//------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (csrRe)
		begin
			case (csrOfs)
				cOfsDiv:    csrRdData <= csrDataT'(div);
				cOfsCsHold: csrRdData <= csrDataT'(csHold);
				cOfsTxData: csrRdData <= csrDataT'(txByte);
				cOfsStart:  csrRdData <= csrDataT'(seqBusy | startPulse);	// Pending counts
				cOfsCsCtrl: csrRdData <= csrDataT'(csCtrl);
				cOfsDone:   csrRdData <= csrDataT'(rDone);
				cOfsRxData: csrRdData <= csrDataT'(rRxData);
				default:    csrRdData <= '0;
			endcase
		end
		else
		begin
			csrRdData <= '0;	// Bus sees data only with ack
		end
	end

endmodule

`default_nettype wire

// ==== src/SpiEnginePkg.sv ====
/* Types of the SPI transfer engine
   Used by the register bank, sequencer, shifter and the testbench */
`default_nettype none

package SpiEnginePkg;

	// One byte on MOSI or MISO
	typedef logic [7:0] spiByteT;

	// Transfer sequencer states
	typedef enum logic [1:0]
	{
		Idle   = 2'd0,	// Waiting for a start
		Hold   = 2'd1,	// Chip select settle delay
		Shift  = 2'd2,	// Byte on the wire
		Finish = 2'd3	// Latch result, pulse done
	} seqStateT;

endpackage

`default_nettype wire

// ==== src/SpiFlashTop.sv ====
/* Top level of the SPI flash controller
   Wishbone slave, register bank, sequencer and pin shifter wired together */
`timescale 1ns/1ps
`default_nettype none

module SpiFlashTop #(
	parameter int pBusWidth     = 32,
	parameter int pCsrAdrsWidth = 8,
	parameter int pAdrsMap      = 'h03
)(
	input  wire logic                 iSCLK,
	input  wire logic                 iSRST,
	// Wishbone
	input  wire logic                 wbCyc,
	input  wire logic                 wbStb,
	input  wire logic                 wbWe,
	input  wire logic [pBusWidth-1:0] wbAdr,
	input  wire SpiRegPkg::csrDataT   wbDatWr,
	output SpiRegPkg::csrDataT        wbDatRd,
	output logic                      wbAck,
	// Flash pins
	output logic                      spiSclk,
	output logic                      spiCs,
	output logic                      spiMosi,
	input  wire logic                 spiMiso
);

	import SpiRegPkg::*;
	import SpiEnginePkg::*;

	// Bus side -----------------------
	logic    csrWe;
	logic    csrRe;
	csrOfsT  csrOfs;
	csrDataT csrWrData;
	csrDataT csrRdData;
	// Engine side --------------------
	logic    startPulse;
	spiByteT txByte;
	spiByteT div;
	spiByteT csHold;
	logic    csCtrl;
	logic    seqBusy;
	logic    seqDone;
	spiByteT seqRxByte;
	logic    shiftGo;
	spiByteT shiftTx;
	logic    shiftDone;
	spiByteT shiftRx;

	SpiWbSlave #(
		.pBusWidth     (pBusWidth),
		.pCsrAdrsWidth (pCsrAdrsWidth),
		.pAdrsMap      (pAdrsMap)
	) uWbSlave (
		.iSCLK(iSCLK), .iSRST(iSRST),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatWr(wbDatWr), .csrRdData(csrRdData),
		.wbAck(wbAck), .wbDatRd(wbDatRd),
		.csrWe(csrWe), .csrRe(csrRe), .csrOfs(csrOfs), .csrWrData(csrWrData)
	);

	SpiCsr uCsr (
		.iSCLK(iSCLK), .iSRST(iSRST),
		.csrWe(csrWe), .csrRe(csrRe), .csrOfs(csrOfs), .csrWrData(csrWrData),
		.seqBusy(seqBusy), .seqDone(seqDone), .seqRxByte(seqRxByte),
		.csrRdData(csrRdData), .startPulse(startPulse), .txByte(txByte),
		.div(div), .csHold(csHold), .csCtrl(csCtrl)
	);

	SpiSeq uSeq (
		.iSCLK(iSCLK), .iSRST(iSRST),
		.startPulse(startPulse), .txByte(txByte), .csHold(csHold),
		.shiftDone(shiftDone), .shiftRx(shiftRx),
		.busy(seqBusy), .done(seqDone), .rxByte(seqRxByte),
		.shiftGo(shiftGo), .shiftTx(shiftTx)
	);

	// Divider and chip select come straight from the register bank
	SpiShifter uShifter (
		.iSCLK(iSCLK), .iSRST(iSRST),
		.shiftGo(shiftGo), .shiftTx(shiftTx), .div(div), .csCtrl(csCtrl),
		.spiMiso(spiMiso),
		.shiftDone(shiftDone), .shiftRx(shiftRx),
		.spiSclk(spiSclk), .spiMosi(spiMosi), .spiCs(spiCs)
	);

endmodule

`default_nettype wire

// ==== src/SpiRegPkg.sv ====
/* Register map of the SPI flash controller: bus word types, offsets and reset values
   Shared by the register bank and the testbench */
`default_nettype none

package SpiRegPkg;

	localparam int cBusWidth = 32;	// Wishbone data width
	localparam int cOfsWidth = 8;	// Offset field inside the block

	typedef logic [cBusWidth-1:0] csrDataT;
	typedef logic [cOfsWidth-1:0] csrOfsT;

	// Register offsets -------------
	localparam csrOfsT cOfsDiv    = 8'h0C;	// SCLK divider
	localparam csrOfsT cOfsCsHold = 8'h10;	// CS to first edge delay
	localparam csrOfsT cOfsTxData = 8'h14;
	localparam csrOfsT cOfsStart  = 8'h18;	// Write 1 to start, reads busy
	localparam csrOfsT cOfsCsCtrl = 8'h1C;	// Chip select level
	localparam csrOfsT cOfsDone   = 8'h30;	// Write clears
	localparam csrOfsT cOfsRxData = 8'h90;

	// Reset values -----------------
	localparam logic [7:0] cDivReset    = 8'd4;
	localparam logic [7:0] cCsHoldReset = 8'd20;

endpackage

`default_nettype wire

// ==== src/SpiSeq.sv ====
/* Transfer sequencer of the SPI flash block
   Runs one byte per start: chip select hold delay, shift, then a done pulse */
`timescale 1ns/1ps
`default_nettype none

module SpiSeq (
	input  wire logic                  iSCLK,
	input  wire logic                  iSRST,
	input  wire logic                  startPulse,
	input  wire SpiEnginePkg::spiByteT txByte,
	input  wire SpiEnginePkg::spiByteT csHold,
	input  wire logic                  shiftDone,
	input  wire SpiEnginePkg::spiByteT shiftRx,
	output logic                       busy,
	output logic                       done,
	output SpiEnginePkg::spiByteT      rxByte,
	output logic                       shiftGo,
	output SpiEnginePkg::spiByteT      shiftTx
);

	import SpiEnginePkg::*;

	seqStateT rState;
	spiByteT  rHoldCnt;	// Clocks left before the first SCLK edge

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rState   <= Idle;
			rHoldCnt <= '0;
			shiftGo  <= 1'b0;
			done     <= 1'b0;
		end
		else
		begin
			shiftGo <= 1'b0;
			done    <= 1'b0;
			case (rState)
				Idle:
				begin
					if (startPulse)
					begin
						rHoldCnt <= csHold;
						rState   <= Hold;
					end
				end
				Hold:
				begin
					// csHold + 1 clocks in this state
					if (rHoldCnt == '0)
					begin
						shiftGo <= 1'b1;
						rState  <= Shift;
					end
					else
					begin
						rHoldCnt <= rHoldCnt - 1'b1;
					end
				end
				Shift:
				begin
					if (shiftDone)
						rState <= Finish;
				end
				Finish:
				begin
					done   <= 1'b1;	// Lines up with the latched byte
					rState <= Idle;
				end
				default: rState <= Idle;
			endcase
		end
	end

	// Byte is held for the whole transfer
	always_ff @(posedge iSCLK)
	begin
		if ((rState == Idle) && startPulse)
			shiftTx <= txByte;
		if (rState == Finish)
			rxByte <= shiftRx;
	end

	assign busy = (rState != Idle);

endmodule

`default_nettype wire

// ==== src/SpiShifter.sv ====
/* SCLK divider and mode-0 shift register on the SPI flash pins
   Moves one byte MSB first per go and reports completion with a pulse */
`timescale 1ns/1ps
`default_nettype none

module SpiShifter (
	input  wire logic                  iSCLK,
	input  wire logic                  iSRST,
	input  wire logic                  shiftGo,
	input  wire SpiEnginePkg::spiByteT shiftTx,
	input  wire SpiEnginePkg::spiByteT div,
	input  wire logic                  csCtrl,
	input  wire logic                  spiMiso,
	output logic                       shiftDone,
	output SpiEnginePkg::spiByteT      shiftRx,
	output logic                       spiSclk,
	output logic                       spiMosi,
	output logic                       spiCs
);

	import SpiEnginePkg::*;

	logic       rActive;
	spiByteT    rDivCnt;
	logic [3:0] rEdgeCnt;	// 16 edges per byte
	spiByteT    rTxSr;
	logic       tick;

	assign tick = rActive & (rDivCnt == '0);	// SCLK toggles on this clock

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rActive   <= 1'b0;
			rDivCnt   <= '0;
			rEdgeCnt  <= '0;
			spiSclk   <= 1'b0;
			spiMosi   <= 1'b0;
			spiCs     <= 1'b1;
			shiftDone <= 1'b0;
		end
		else
		begin
			spiCs     <= csCtrl;	// Software owns chip select
			shiftDone <= 1'b0;
			if (shiftGo)
			begin
				rActive  <= 1'b1;
				rDivCnt  <= div;
				rEdgeCnt <= '0;
				spiSclk  <= 1'b0;
				spiMosi  <= shiftTx[7];	// MSB ready before first rise
			end
			else if (tick)
			begin
				rDivCnt  <= div;
				spiSclk  <= ~spiSclk;
				rEdgeCnt <= rEdgeCnt + 1'b1;
				if (spiSclk)
					spiMosi <= rTxSr[6];	// Falling edge
				if (rEdgeCnt == 4'd15)
				begin
					rActive   <= 1'b0;
					shiftDone <= 1'b1;
				end
			end
			else if (rActive)
			begin
				rDivCnt <= rDivCnt - 1'b1;
			end
		end
	end

	// Data path
	always_ff @(posedge iSCLK)
	begin
		if (shiftGo)
			rTxSr <= shiftTx;
		else if (tick & spiSclk)
			rTxSr <= {rTxSr[6:0], 1'b0};
		if (tick & ~spiSclk)
			shiftRx <= {shiftRx[6:0], spiMiso};	// Sample on rising edge
	end

endmodule

`default_nettype wire

// ==== src/SpiWbSlave.sv ====
/* Wishbone classic slave of the SPI flash block
   Turns a matching bus cycle into one register strobe and returns ack a clock later */
`timescale 1ns/1ps
`default_nettype none

module SpiWbSlave #(
	parameter int pBusWidth     = 32,
	parameter int pCsrAdrsWidth = 8,
	parameter int pAdrsMap      = 'h03
)(
	input  wire logic               iSCLK,
	input  wire logic               iSRST,
	input  wire logic               wbCyc,
	input  wire logic               wbStb,
	input  wire logic               wbWe,
	input  wire logic [pBusWidth-1:0] wbAdr,
	input  wire SpiRegPkg::csrDataT wbDatWr,
	input  wire SpiRegPkg::csrDataT csrRdData,
	output logic                    wbAck,
	output SpiRegPkg::csrDataT      wbDatRd,
	output logic                    csrWe,
	output logic                    csrRe,
	output SpiRegPkg::csrOfsT       csrOfs,
	output SpiRegPkg::csrDataT      csrWrData
);

	logic baseHit;
	logic cycHit;
	logic access;
	logic rSeen;	// Cycle already served

	// Block base sits above the offset field
	assign baseHit = (wbAdr[pBusWidth-1:pCsrAdrsWidth] ==
		(pBusWidth-pCsrAdrsWidth)'(pAdrsMap));
	assign cycHit  = wbCyc & wbStb & baseHit;
	assign access  = cycHit & ~rSeen;	// First clock of the cycle only

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rSeen <= 1'b0;
			wbAck <= 1'b0;
		end
		else
		begin
			rSeen <= cycHit;	// Falls once the master drops stb
			wbAck <= access;
		end
	end

	assign csrWe     = access & wbWe;
	assign csrRe     = access & ~wbWe;
	assign csrOfs    = wbAdr[pCsrAdrsWidth-1:0];
	assign csrWrData = wbDatWr;
	assign wbDatRd   = csrRdData;	// Bank registers it in step with ack

endmodule

`default_nettype wire

// ==== tb/SpiFlashTb.sv ====
/* Testbench of the SPI flash controller with Wishbone bus tasks, a flash model on the pins
   and vectors read from tb/spiFlashInput.txt */
`timescale 1ns/1ps
`default_nettype none

module SpiFlashTb;

	import SpiRegPkg::*;
	import SpiEnginePkg::*;

	localparam int cBusWidth    = 32;
	localparam int cAdrsWidth   = 8;
	localparam int cAdrsMap     = 'h03;
	localparam int cMaxWords    = 256;
	localparam int cAckTimeout  = 20;	// Clocks
	localparam int cDoneTimeout = 4000;	// Polls of Done
	localparam int cSeed        = 90968;

	// Vector operations
	localparam csrDataT cOpWrite  = 'h0;
	localparam csrDataT cOpRead   = 'h1;
	localparam csrDataT cOpXfer   = 'h2;
	localparam csrDataT cOpRandom = 'h3;
	localparam csrDataT cOpBusy   = 'h4;
	localparam csrDataT cOpEnd    = 'hF;

	logic                 iSCLK;
	logic                 iSRST;
	logic                 wbCyc;
	logic                 wbStb;
	logic                 wbWe;
	logic [cBusWidth-1:0] wbAdr;
	csrDataT              wbDatWr;
	csrDataT              wbDatRd;
	logic                 wbAck;
	logic                 spiSclk;
	logic                 spiCs;
	logic                 spiMosi;
	logic                 spiMiso;

	csrDataT vecMem [0:cMaxWords-1];
	spiByteT replyByte;	// Flash model answer
	spiByteT mosiCap;
	int      sclkRises;
	int      fallCnt;
	int      errCount;
	int      checkCount;
	int      testCount;
	int      vecIdx;
	int      seedDummy;
	logic    timedOut;
	logic    finished;

	SpiFlashTop #(
		.pBusWidth     (cBusWidth),
		.pCsrAdrsWidth (cAdrsWidth),
		.pAdrsMap      (cAdrsMap)
	) UUT (
		.iSCLK(iSCLK), .iSRST(iSRST),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatWr(wbDatWr), .wbDatRd(wbDatRd), .wbAck(wbAck),
		.spiSclk(spiSclk), .spiCs(spiCs), .spiMosi(spiMosi), .spiMiso(spiMiso)
	);

	always #50 iSCLK = ~iSCLK;

	// Flash model --------------------
	always @(posedge spiSclk or posedge spiCs)
	begin
		if (spiCs !== 1'b0)
		begin
			mosiCap   = '0;	// New frame
			sclkRises = 0;
		end
		else
		begin
			mosiCap   = {mosiCap[6:0], spiMosi};
			sclkRises = sclkRises + 1;
		end
	end

	always @(negedge spiSclk or posedge spiCs)
	begin
		if (spiCs !== 1'b0)
			fallCnt = 0;
		else
			fallCnt = fallCnt + 1;	// Next bit after each fall
	end

	assign spiMiso = ((spiCs === 1'b0) && (fallCnt < 8)) ? replyByte[7 - fallCnt] : 1'b0;

	// Compare tasks ------------------
	task automatic checkWord(input string name, input csrDataT expVal, input csrDataT gotVal);
		checkCount++;
		if (gotVal !== expVal)
		begin
			$display("** Error at %0d ns: %s expected %h, got %h", $time, name, expVal, gotVal);
			errCount++;
		end
	endtask

	task automatic checkByte(input string name, input spiByteT expVal, input spiByteT gotVal);
		checkCount++;
		if (gotVal !== expVal)
		begin
			$display("** Error at %0d ns: %s expected %h, got %h", $time, name, expVal, gotVal);
			errCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic expVal, input logic gotVal);
		checkCount++;
		if (gotVal !== expVal)
		begin
			$display("** Error at %0d ns: %s expected %b, got %b", $time, name, expVal, gotVal);
			errCount++;
		end
	endtask

	function automatic string regName(input csrOfsT ofs);
		case (ofs)
			cOfsDiv:    return "Div";
			cOfsCsHold: return "CsHold";
			cOfsTxData: return "TxData";
			cOfsStart:  return "Start";
			cOfsCsCtrl: return "CsCtrl";
			cOfsDone:   return "Done";
			cOfsRxData: return "RxData";
			default:    return "Unmapped";
		endcase
	endfunction

	// Bus tasks ----------------------
	task automatic wbAccess(input logic we, input csrOfsT ofs, input csrDataT data,
		output csrDataT rdData);
		int waitCnt;
		waitCnt = 0;
		rdData  = '0;
		if (timedOut)
			return;
		@(negedge iSCLK);
		wbCyc   = 1'b1;
		wbStb   = 1'b1;
		wbWe    = we;
		wbAdr   = {(cBusWidth-cAdrsWidth)'(cAdrsMap), ofs};
		wbDatWr = data;
		@(negedge iSCLK);
		while (!wbAck && (waitCnt < cAckTimeout))
		begin
			@(negedge iSCLK);
			waitCnt++;
		end
		if (wbAck)
			rdData = wbDatRd;	// Valid with ack
		else
		begin
			$display("Timeout: no wbAck for access to offset %h", ofs);
			timedOut = 1'b1;
			errCount++;
		end
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe  = 1'b0;
	endtask

	task automatic wbWrite(input csrOfsT ofs, input csrDataT data);
		csrDataT unused;
		wbAccess(1'b1, ofs, data, unused);
	endtask

	task automatic wbRead(input csrOfsT ofs, output csrDataT data);
		wbAccess(1'b0, ofs, '1, data);	// Write lines busy, slave must ignore them
	endtask

	task automatic waitDone;
		int      polls;
		csrDataT word;
		polls = 0;
		wbRead(cOfsDone, word);
		while ((word[0] !== 1'b1) && (polls < cDoneTimeout) && !timedOut)
		begin
			wbRead(cOfsDone, word);
			polls++;
		end
		if ((word[0] !== 1'b1) && !timedOut)
		begin
			$display("Timeout: Done never read 1 after a start");
			timedOut = 1'b1;
			errCount++;
		end
	endtask

	// Checks after the sequencer finished one byte
	task automatic checkResult(input spiByteT tx, input spiByteT reply);
		csrDataT word;
		wbRead(cOfsStart, word);
		checkBit("Start", 1'b0, word[0]);
		wbRead(cOfsRxData, word);
		checkWord("RxData", csrDataT'(reply), word);
		checkByte("spiMosi byte", tx, mosiCap);
		checkWord("SCLK rises", 32'd8, csrDataT'(sclkRises));
	endtask

	task automatic runXfer(input spiByteT tx, input spiByteT reply);
		replyByte = reply;
		wbWrite(cOfsDone, '0);	// Clear old result
		wbWrite(cOfsTxData, csrDataT'(tx));
		wbWrite(cOfsCsCtrl, '0);
		wbWrite(cOfsStart, 32'd1);
		waitDone();
		checkResult(tx, reply);
		wbWrite(cOfsCsCtrl, 32'd1);
	endtask

	task automatic runBusyStart(input spiByteT tx, input spiByteT reply);
		csrDataT word;
		replyByte = reply;
		wbWrite(cOfsDone, '0);
		wbWrite(cOfsTxData, csrDataT'(tx));
		wbWrite(cOfsCsCtrl, '0);
		wbWrite(cOfsStart, 32'd1);
		wbWrite(cOfsStart, 32'd1);	// Lands during the hold delay
		wbRead(cOfsStart, word);
		checkBit("Start", 1'b1, word[0]);
		waitDone();
		checkResult(tx, reply);
		wbWrite(cOfsDone, '0);
		wbRead(cOfsDone, word);
		checkBit("Done", 1'b0, word[0]);
		wbWrite(cOfsCsCtrl, 32'd1);
	endtask

	task automatic runVector(input csrDataT op, input csrDataT ofs, input csrDataT data,
		input csrDataT expVal);
		int      errBefore;
		csrDataT word;
		errBefore = errCount;
		testCount++;
		case (op)
			cOpWrite: wbWrite(csrOfsT'(ofs), data);
			cOpRead:
			begin
				wbRead(csrOfsT'(ofs), word);
				checkWord(regName(csrOfsT'(ofs)), expVal, word);
			end
			cOpXfer:   runXfer(spiByteT'(data), spiByteT'(expVal));
			cOpRandom:
			begin
				wbWrite(cOfsDiv, data);
				for (int k = 0; k < int'(expVal); k++)
					runXfer(spiByteT'($urandom), spiByteT'($urandom));
			end
			cOpBusy: runBusyStart(spiByteT'(data), spiByteT'(expVal));
			default:
			begin
				$display("Unknown operation %h in vector %0d", op, testCount);
				errCount++;
			end
		endcase
		$display("Vector %0d op %0h offset %h: %s", testCount, op, ofs,
			(errCount == errBefore) ? "ok" : "FAILED");
	endtask

	//------------------------------
	// Main sequence
	//------------------------------
	initial
	begin
		iSCLK      = 1'b0;
		iSRST      = 1'b1;
		wbCyc      = 1'b0;
		wbStb      = 1'b0;
		wbWe       = 1'b0;
		wbAdr      = '0;
		wbDatWr    = '0;
		replyByte  = '0;
		errCount   = 0;
		checkCount = 0;
		testCount  = 0;
		vecIdx     = 0;
		timedOut   = 1'b0;
		finished   = 1'b0;
		seedDummy  = $urandom(cSeed);
		$readmemh("tb/spiFlashInput.txt", vecMem);
		repeat (8) @(negedge iSCLK);
		iSRST = 1'b0;

		while (!finished && !timedOut && (vecIdx + 3 < cMaxWords))
		begin
			if ($isunknown(vecMem[vecIdx]))
			begin
				$display("Vector file missing or cut short at vector %0d", vecIdx / 4);
				errCount++;
				finished = 1'b1;
			end
			else if (vecMem[vecIdx] == cOpEnd)
				finished = 1'b1;
			else
			begin
				runVector(vecMem[vecIdx], vecMem[vecIdx+1], vecMem[vecIdx+2], vecMem[vecIdx+3]);
				vecIdx += 4;
			end
		end
		if (!finished && !timedOut)
		begin
			$display("Vector list has no end marker");
			errCount++;
		end

		$display("Vectors %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/SpiFlashTb_sva.sv ====
/* Bus and pin assertions for the SPI flash controller, bound into its top level */
`timescale 1ns/1ps
`default_nettype none

module SpiFlashSva (
	input wire logic iSCLK,
	input wire logic iSRST,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbAck,
	input wire logic spiSclk,
	input wire logic spiCs
);

	// Ack lasts exactly one clock
	ackSingle: assert property (@(posedge iSCLK) disable iff (iSRST) wbAck |=> !wbAck)
		else $error("wbAck high for two consecutive cycles");

	ackAfterStb: assert property (@(posedge iSCLK) disable iff (iSRST)
		wbAck |-> $past(wbCyc & wbStb))
		else $error("wbAck without a preceding strobe");

	sclkIdle: assert property (@(posedge iSCLK) disable iff (iSRST) spiCs |-> !spiSclk)
		else $error("spiSclk active while chip select is high");	// Mode 0 idles low

endmodule

bind SpiFlashTop SpiFlashSva uSva (
	.iSCLK(iSCLK), .iSRST(iSRST), .wbCyc(wbCyc), .wbStb(wbStb),
	.wbAck(wbAck), .spiSclk(spiSclk), .spiCs(spiCs)
);

`default_nettype wire

// ==== tb/spiFlashInput.txt ====
// op offset data expected: op 0 write, 1 read-check, 2 transfer (data tx, expected reply)
// 3 random transfers (data div, expected count), 4 start while busy (tx, reply), F end
1 0C 0 4
1 10 0 14
1 1C 0 1
1 30 0 0
1 18 0 0
1 24 0 0
0 0C 1A5 0
1 0C 0 A5
0 10 233 0
1 10 0 33
0 14 3C7 0
1 14 0 C7
0 1C FE 0
1 1C 0 0
0 1C 1 0
0 10 3 0
0 0C 2 0
2 14 9F C2
2 14 00 FF
3 0C 0 3
3 0C 1 2
3 0C 6 2
4 14 5A 81
1 30 0 0
F 0 0 0
